/* cen_hub.f */
+incdir+logic
logic/cen_pkg.sv
logic/cen_cfg_regs.sv
logic/cen_fixed_div.sv
logic/cen_frac_div.sv
logic/cen_out_gate.sv
logic/cen_hub.sv
tb/cen_hub_tb.sv

/* Makefile */
# Verilator build and run for the clock-enable hub testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = cen_hub_tb
FILELIST  = cen_hub.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/cen_cases.txt */
# mode (0 frac, 1 int), cfg word (hex), window cycles, expected cen_main, expected cen_half
# frac word is {step[10:0], lim[10:0]}, int word is {6 spare bits, period[15:0]}
0 34d80 2816 210 105
0 00802 1000 500 250
0 01810 1600 300 150
0 03be8 3000 21 10
0 100600 900 300 150
1 0007d 2500 20 10
1 0000a 1000 100 50
1 00001 200 200 100
1 00000 100 100 50
1 00003 999 333 166
1 007d0 8000 4 2
0 34d80 1408 105 52

/* tb/cen_hub_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for the clock-enable hub
// Fixed ratios and phases, frac and int cases from file,
// pause alignment, reconfiguration while running
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cen_params.svh"

module cen_hub_tb
    import cen_pkg::*;
();

    localparam int CLK_HALF = 4;       // 8 ns clock
    localparam int FIX_WIN  = 960;     // Multiple of every fixed period

    logic      clk;
    logic      arst_n;
    logic      cfg_we;
    cen_mode_e cfg_mode;
    cen_cfg_u  cfg_data;
    logic      pause;
    cen_out_t  cen;

    // Case table
    int                    c_mode [$];
    logic [`CEN_CFG_W-1:0] c_word [$];
    int                    c_win  [$];
    int                    c_main [$];
    int                    c_half [$];

    int          mismatch_cnt;
    int          other_cnt;
    integer      seed;
    int          cyc;              // Cycles since reset release
    logic        counting;         // Monitor controls
    logic        phase_chk;
    logic        spacing_chk;
    int          exp_gap;
    int          last_main;
    logic [3:0]  q_hist;           // Recent cen3q samples
    logic [12:0] fv;
    int          fix_cnt [12:0];
    int          main_cnt;
    int          half_cnt;
    // Indexed by bit of cen_fixed_t with cen12 at bit 12
    int          exp_fix [12:0] = '{240, 240, 320, 160, 120, 120, 80, 60, 60, 60, 60, 30, 30};
    string       fix_name [12:0] = '{"cen12", "cen12b", "cen16", "cen8", "cen6", "cen6b",
                                     "cen4", "cen3", "cen3b", "cen3q", "cen3qb",
                                     "cen1p5", "cen1p5b"};

    cen_hub dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .cfg_we   (cfg_we),
        .cfg_mode (cfg_mode),
        .cfg_data (cfg_data),
        .pause    (pause),
        .cen      (cen)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers

    task automatic abort_run(string why);
        other_cnt = other_cnt + 1;
        $display("%s", why);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic check_excl(int a, int b);
        if (fv[a] && fv[b]) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch at %0t: %s and %s high together", $time,
                     fix_name[a], fix_name[b]);
        end
    endtask

    // Window edges may add or drop one pulse
    task automatic check_close(string what, int got, int exp);
        if (got - exp > 1 || exp - got > 1) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch at %0t: %s count %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic count_window(int n);
        int i;
        @(posedge clk);
        for (i = 0; i < 13; i++) begin
            fix_cnt[i] = 0;
        end
        main_cnt = 0;
        half_cnt = 0;
        counting = 1'b1;
        repeat (n) @(posedge clk);     // n negedges counted
        counting = 1'b0;
    endtask

    task automatic write_config(int mode, logic [`CEN_CFG_W-1:0] word);
        @(posedge clk);
        cfg_we   <= 1'b1;
        cfg_data <= word;
        if (mode == 1) cfg_mode <= MODE_INT;
        else           cfg_mode <= MODE_FRAC;
        @(posedge clk);
        cfg_we <= 1'b0;
        repeat (4) @(posedge clk);     // Restart reaches the outputs
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor on the falling edge

    always @(negedge clk) begin
        if (arst_n) begin
            cyc = cyc + 1;
            fv  = cen.fixed;
            check_excl(12, 11);
            check_excl(8, 7);
            check_excl(5, 4);
            check_excl(3, 2);
            check_excl(1, 0);
            if (!phase_chk) q_hist = '0;
            else begin
                if (q_hist[3] && !fv[5]) begin  // cen3q four cycles ago
                    mismatch_cnt = mismatch_cnt + 1;
                    $display("Mismatch at %0t: cen3q not followed by cen3", $time);
                end
                q_hist = {q_hist[2:0], fv[3]};
            end
            if (counting) begin
                for (int i = 0; i < 13; i++) begin
                    if (fv[i]) fix_cnt[i] = fix_cnt[i] + 1;
                end
                if (cen.prog.cen_main) main_cnt = main_cnt + 1;
                if (cen.prog.cen_half) half_cnt = half_cnt + 1;
            end
            if (spacing_chk && cen.prog.cen_main) begin
                if (last_main >= 0 && cyc - last_main != exp_gap) begin
                    mismatch_cnt = mismatch_cnt + 1;
                    $display("Mismatch at %0t: cen_main gap %0d, expected %0d", $time,
                             cyc - last_main, exp_gap);
                end
                last_main = cyc;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Scenarios

    // Fixed bank counts plus the divider's reset default
    task automatic check_fixed_ratios();
        int i;
        int own_main;
        own_main = FIX_WIN * `CEN_DEF_STEP / `CEN_DEF_LIM;
        repeat (40) @(posedge clk);
        count_window(FIX_WIN);
        for (i = 0; i < 13; i++) begin
            if (fix_cnt[i] != exp_fix[i]) begin
                mismatch_cnt = mismatch_cnt + 1;
                $display("Mismatch at %0t: %s count %0d, expected %0d", $time,
                         fix_name[i], fix_cnt[i], exp_fix[i]);
            end
        end
        check_close("default cen_main", main_cnt, own_main);
        check_close("default cen_half", half_cnt, own_main / 2);
    endtask

    // Write lands mid-run with the divider still running
    task automatic run_case(int k);
        cen_cfg_u cw;
        int       own_main;
        int       per;
        int       gap;
        cw  = c_word[k];
        gap = int'($unsigned($random(seed)) % 20);
        repeat (gap) @(posedge clk);
        write_config(c_mode[k], c_word[k]);
        if (c_mode[k] == 0) begin
            own_main = c_win[k] * int'(cw.frac.step) / int'(cw.frac.lim);
        end else begin
            per = int'(cw.intv.period);
            if (per < 2) per = 1;            // 0 and 1 pulse every cycle
            own_main    = c_win[k] / per;
            exp_gap     = per;
            last_main   = -1;
            spacing_chk = 1'b1;
        end
        if (own_main != c_main[k]) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch at %0t: case %0d file expects %0d, rule gives %0d", $time,
                     k, c_main[k], own_main);
        end
        count_window(c_win[k]);
        spacing_chk = 1'b0;
        check_close("cen_main", main_cnt, own_main);
        check_close("cen_half", half_cnt, c_half[k]);
        check_close("cen_half against half cen_main", half_cnt, main_cnt / 2);
        $display("Case %0d: mode %0d, %0d cen_main, %0d cen_half", k, c_mode[k],
                 main_cnt, half_cnt);
    endtask

    task automatic pause_round();
        int len;
        int n;
        int k;
        len = 40 + int'($unsigned($random(seed)) % 80);
        phase_chk = 1'b0;
        @(posedge clk);
        pause <= 1'b1;
        repeat (36) @(negedge clk);    // Next boundary plus gate stage
        for (n = 36; n < len; n++) begin
            if (cen != '0) begin
                mismatch_cnt = mismatch_cnt + 1;
                $display("Mismatch at %0t: enable high while paused", $time);
            end
            @(negedge clk);
        end
        @(posedge clk);
        pause <= 1'b0;
        // First boundary after release and then exact gaps
        for (k = 0; k < 5; k++) begin
            n = 0;
            do begin
                @(negedge clk);
                n = n + 1;
            end while (!cen.fixed.cen1p5 && n < 40);
            if (!cen.fixed.cen1p5) abort_run("Timeout waiting for cen1p5 after pause release");
            else if (k > 0 && n != 32) begin
                mismatch_cnt = mismatch_cnt + 1;
                $display("Mismatch at %0t: cen1p5 gap %0d after release", $time, n);
            end
        end
        phase_chk = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int                    fd;
        int                    r;
        string                 line;
        int                    m;
        int                    w;
        int                    mn;
        int                    hf;
        logic [`CEN_CFG_W-1:0] word;
        seed         = 98;
        mismatch_cnt = 0;
        other_cnt    = 0;
        cyc          = 0;
        counting     = 1'b0;
        phase_chk    = 1'b0;
        spacing_chk  = 1'b0;
        exp_gap      = 1;
        last_main    = -1;
        q_hist       = '0;
        arst_n       = 1'b0;
        cfg_we       = 1'b0;
        cfg_mode     = MODE_FRAC;
        cfg_data     = '0;
        pause        = 1'b0;
        fd = $fopen("tb/cen_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r > 0) begin
                    r = $sscanf(line, "%d %h %d %d %d", m, word, w, mn, hf);
                    if (r == 5) begin      // Comment lines give 0
                        c_mode.push_back(m);
                        c_word.push_back(word);
                        c_win.push_back(w);
                        c_main.push_back(mn);
                        c_half.push_back(hf);
                    end
                end
            end
            $fclose(fd);
        end
        if (c_mode.size() == 0) abort_run("Cannot read any case from tb/cen_cases.txt");
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (cen !== '0) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch at %0t: enables not low after reset", $time);
        end
        phase_chk = 1'b1;
        check_fixed_ratios();
        pause_round();
        for (int k = 0; k < c_mode.size(); k++) begin
            run_case(k);
        end
        pause_round();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* logic/cen_hub.sv */
////////////////////////////////////////////////////////////
// Clock-enable hub top level
// Config regs, fixed bank, programmable divider, gate
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cen_hub
    import cen_pkg::*;
(
    input  logic      clk,         // 48 MHz
    input  logic      arst_n,
    input  logic      cfg_we,
    input  cen_mode_e cfg_mode,
    input  cen_cfg_u  cfg_data,
    input  logic      pause,
    output cen_out_t  cen
);

    cen_mode_e  mode;
    cen_cfg_u   cfg;
    logic       restart;
    cen_fixed_t fixed;
    cen_prog_t  prog;

    cen_cfg_regs u_cfg_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .cfg_we   (cfg_we),
        .cfg_mode (cfg_mode),
        .cfg_data (cfg_data),
        .mode     (mode),
        .cfg      (cfg),
        .restart  (restart)
    );

    cen_fixed_div u_fixed_div (
        .clk    (clk),
        .arst_n (arst_n),
        .fixed  (fixed)
    );

    cen_frac_div u_frac_div (
        .clk     (clk),
        .arst_n  (arst_n),
        .mode    (mode),
        .cfg     (cfg),
        .restart (restart),
        .prog    (prog)
    );

    // One cycle behind the dividers
    cen_out_gate u_out_gate (
        .clk    (clk),
        .arst_n (arst_n),
        .pause  (pause),
        .fixed  (fixed),
        .prog   (prog),
        .cen    (cen)
    );

endmodule

/* logic/cen_out_gate.sv */
////////////////////////////////////////////////////////////
// Output stage
// Registers all enables, pause applied on 1.5 MHz edges
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cen_out_gate
    import cen_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       pause,      // Level, any time
    input  cen_fixed_t fixed,
    input  cen_prog_t  prog,
    output cen_out_t   cen
);

    logic paused;
    logic paused_nxt;

    // Pause only moves on a cen1p5 cycle, so phases stay aligned
    always_comb begin
        paused_nxt = paused;
        if (fixed.cen1p5) paused_nxt = pause;
    end

    ////////////////////////////////////////////////////////////
    // Pause flag and output register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            paused <= 1'b0;
            cen    <= '0;
        end else begin
            paused <= paused_nxt;
            // Boundary pulse follows the new state
            if (paused_nxt) cen <= '0;
            else            cen <= '{fixed: fixed, prog: prog};
        end
    end

endmodule

/* logic/cen_frac_div.sv */
////////////////////////////////////////////////////////////
// Programmable divider
// Fractional step/limit accumulator or integer period
// counter, plus a half-rate enable
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cen_params.svh"

module cen_frac_div
    import cen_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  cen_mode_e mode,
    input  cen_cfg_u  cfg,
    input  logic      restart,     // Clears count and toggle
    output cen_prog_t prog
);

    logic [`CEN_PER_W-1:0] cnt;           // Accumulator or period count
    logic                  alt;           // Half-rate toggle
    logic [`CEN_PER_W-1:0] step_x;
    logic [`CEN_PER_W-1:0] lim_x;
    logic [`CEN_PER_W-1:0] frac_next;
    logic [`CEN_PER_W-1:0] frac_max;
    logic [`CEN_PER_W:0]   int_next;      // Extra bit, no wrap
    logic [`CEN_PER_W-1:0] cnt_nxt;
    logic                  hit;
    logic                  bad;

    ////////////////////////////////////////////////////////////
    // Next count

    always_comb begin
        // Widened so step + lim cannot overflow
        step_x    = `CEN_PER_W'(cfg.frac.step);
        lim_x     = `CEN_PER_W'(cfg.frac.lim);
        frac_next = cnt + step_x;
        frac_max  = lim_x + step_x;
        int_next  = {1'b0, cnt} + (`CEN_PER_W+1)'(1);
        hit       = 1'b0;
        bad       = 1'b0;
        if (mode == MODE_FRAC) begin
            bad     = cnt >= frac_max;             // Out of range, recover
            hit     = frac_next >= lim_x;
            cnt_nxt = hit ? frac_next - lim_x : frac_next;
        end else begin
            // Period 0 or 1 hits every cycle
            hit     = int_next >= {1'b0, cfg.intv.period};
            cnt_nxt = hit ? '0 : int_next[`CEN_PER_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Count and outputs

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            alt  <= 1'b0;
            prog <= '0;
        end else begin
            prog <= '0;                            // Single-cycle pulses
            if (restart || bad) begin
                cnt <= '0;
                alt <= 1'b0;
            end else begin
                cnt <= cnt_nxt;
                if (hit) begin
                    prog.cen_main <= 1'b1;
                    prog.cen_half <= alt;          // Every second hit
                    alt           <= ~alt;
                end
            end
        end
    end

endmodule

/* logic/cen_fixed_div.sv */
////////////////////////////////////////////////////////////
// Fixed divider bank, 48 MHz in
// 12/16/8/6/4/3/1.5 MHz enables with shifted copies
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cen_fixed_div
    import cen_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    output cen_fixed_t fixed
);

    logic [4:0] cnt;       // Binary, powers of two
    logic [2:0] cnt6;      // Mod 6, for 8 and 16 MHz
    logic       cnt12;     // Toggles every 6, for 4 MHz

    ////////////////////////////////////////////////////////////
    // Counters

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt   <= 5'd0;
            cnt6  <= 3'd0;
            cnt12 <= 1'b0;
        end else begin
            cnt   <= cnt + 5'd1;                     // Free running
            cnt6  <= (cnt6 == 3'd5) ? 3'd0 : cnt6 + 3'd1;
            cnt12 <= cnt12 ^ (cnt6 == 3'd5);
        end
    end

    ////////////////////////////////////////////////////////////
    // Enable decode

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fixed <= '0;
        end else begin
            // 12 MHz, period 4
            fixed.cen12   <= cnt[1:0] == 2'd0;
            fixed.cen12b  <= cnt[1:0] == 2'd2;
            // 16 MHz, two hits per mod-6 turn
            fixed.cen16   <= (cnt6 == 3'd0) || (cnt6 == 3'd3);
            fixed.cen8    <= cnt6 == 3'd0;
            fixed.cen4    <= (cnt6 == 3'd0) && cnt12;   // Every other cen8
            // 6 MHz, period 8
            fixed.cen6    <= cnt[2:0] == 3'd0;
            fixed.cen6b   <= cnt[2:0] == 3'd4;
            // 3 MHz, period 16
            fixed.cen3    <= cnt[3:0] == 4'd0;
            fixed.cen3b   <= cnt[3:0] == 4'd8;
            // 4 cycles ahead of cen3
            fixed.cen3q   <= cnt[3:0] == 4'd12;
            fixed.cen3qb  <= cnt[3:0] == 4'd4;
            // 1.5 MHz, full counter wrap
            fixed.cen1p5  <= cnt == 5'd0;
            fixed.cen1p5b <= cnt == 5'd16;
        end
    end

endmodule

/* logic/cen_cfg_regs.sv */
////////////////////////////////////////////////////////////
// Config register block
// Mode and config word captured on a write strobe,
// restart pulse to the programmable divider
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cen_params.svh"

module cen_cfg_regs
    import cen_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      cfg_we,      // One-cycle strobe
    input  cen_mode_e cfg_mode,
    input  cen_cfg_u  cfg_data,
    output cen_mode_e mode,
    output cen_cfg_u  cfg,
    output logic      restart      // Cycle after the strobe
);

    ////////////////////////////////////////////////////////////
    // Registers

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode           <= MODE_FRAC;
            // Defaults for 3.579545 MHz
            cfg.frac.step  <= `CEN_FRAC_W'(`CEN_DEF_STEP);
            cfg.frac.lim   <= `CEN_FRAC_W'(`CEN_DEF_LIM);
        end else if (cfg_we) begin
            mode <= cfg_mode;
            cfg  <= cfg_data;      // No check, any word accepted
        end
    end

    ////////////////////////////////////////////////////////////
    // Restart pulse

    // New values and restart appear together
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            restart <= 1'b0;
        end else begin
            restart <= cfg_we;
        end
    end

endmodule

/* logic/cen_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the clock-enable hub
// Enable bundles, config word views, divider mode
////////////////////////////////////////////////////////////

`include "cen_params.svh"

package cen_pkg;

    // Fixed bank, one bit per enable
    typedef struct packed {
        logic cen12;
        logic cen12b;   // 180 deg
        logic cen16;
        logic cen8;
        logic cen6;
        logic cen6b;
        logic cen4;
        logic cen3;
        logic cen3b;
        logic cen3q;    // Quarter ahead of cen3
        logic cen3qb;
        logic cen1p5;   // Pause boundary
        logic cen1p5b;
    } cen_fixed_t;

    typedef struct packed {
        logic cen_main;
        logic cen_half; // Every second cen_main
    } cen_prog_t;

    // Same word, read by mode
    typedef union packed {
        struct packed {
            logic [`CEN_FRAC_W-1:0] step;
            logic [`CEN_FRAC_W-1:0] lim;
        } frac;
        struct packed {
            logic [`CEN_CFG_W-`CEN_PER_W-1:0] spare;
            logic [`CEN_PER_W-1:0]            period;
        } intv;
    } cen_cfg_u;

    typedef enum logic {
        MODE_FRAC = 1'b0,
        MODE_INT  = 1'b1
    } cen_mode_e;

    // Top-level output bus
    typedef struct packed {
        cen_fixed_t fixed;
        cen_prog_t  prog;
    } cen_out_t;

endpackage

/* logic/cen_params.svh */
////////////////////////////////////////////////////////////
// Widths and reset defaults for the clock-enable hub
// Clock is 48 MHz; defaults give 3.579545 MHz
////////////////////////////////////////////////////////////

`ifndef CEN_PARAMS_SVH
`define CEN_PARAMS_SVH

// Fractional divider step, limit and accumulator
`define CEN_FRAC_W   11

// Integer period counter
`define CEN_PER_W    16

// Config word, twice the fractional width
`define CEN_CFG_W    22

// 48 MHz * 105 / 1408 = 3.579545 MHz
`define CEN_DEF_STEP 105
`define CEN_DEF_LIM  1408

`endif
